/* pc_keyboard_if.f */
+incdir+src
src/kbd_pkg.sv
src/ps2_receiver.sv
src/scan_translator.sv
src/host_port_fsm.sv
src/pc_keyboard_if.sv
verification/tb_pc_keyboard_if.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f pc_keyboard_if.f \
	--top-module tb_pc_keyboard_if -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "all tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* src/host_port_fsm.sv */
`include "kbd_config.svh"

module host_port_fsm import kbd_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  xt_code_t xt_code,
	input  logic     rx_strobe,
	input  logic     pb6,
	input  logic     pb7,
	output xt_code_t pa,
	output logic     irq1
);

	host_state_t state;
	host_state_t state_next;
	xt_code_t    pa_next;
	xt_code_t    break_code;
	logic        irq1_next;
	logic        is_prefix;

	assign is_prefix = (xt_code == xt_code_t'(`KBD_BREAK_PREFIX));

	// released key, same code with the flag bit forced
	always_comb begin
		break_code = xt_code;
		break_code[`KBD_BREAK_FLAG_BIT] = 1'b1;
	end

	always_comb begin
		state_next = state;
		pa_next    = pa;
		irq1_next  = 1'b0;

		case (state)
			st_idle: begin
				if (!pb6) begin
					state_next = st_test_hold;
				end else if (rx_strobe) begin
					if (is_prefix) begin
						state_next = st_break_wait;
					end else begin
						state_next = st_make_ready;
						pa_next    = xt_code;
					end
				end
			end
			st_break_wait: begin
				if (!pb6) begin
					state_next = st_test_hold;
				end else if (rx_strobe && !is_prefix) begin
					state_next = st_break_ready;
					pa_next    = break_code;
				end // repeated prefix keeps waiting
			end
			st_make_ready, st_break_ready: begin
				if (!pb6) begin
					state_next = st_test_hold;
				end else if (pb7) begin
					state_next = st_wait_clear;
					pa_next    = '0;
				end else begin
					irq1_next = 1'b1; // hold until the PC acknowledges
				end
			end
			st_wait_clear: begin
				if (!pb6)
					state_next = st_test_hold;
				else if (!pb7)
					state_next = st_idle;
			end
			st_test_hold: begin
				if (pb6)
					state_next = st_test_release;
			end
			st_test_release: begin
				// pb6 is not looked at here
				if (!pb7) begin
					state_next = st_make_ready;
					pa_next    = xt_code_t'(`KBD_SELF_TEST_CODE);
				end
			end
			default: begin
				state_next = st_idle;
				pa_next    = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pa    <= '0;
			irq1  <= 1'b0;
		end else begin
			state <= state_next;
			pa    <= pa_next;
			irq1  <= irq1_next;
		end
	end

	// irq1 is only ever raised from one of the two ready states
	a_irq_in_ready: assert property (
		@(posedge clk) disable iff (!rst_n)
		irq1 |-> (state inside {st_make_ready, st_break_ready})
	) else $error("irq1 high outside a ready state");

	// idle is only reached through reset or wait_clear, both leave pa cleared
	a_idle_pa_zero: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == st_idle) |-> (pa == '0)
	) else $error("pa not zero in idle");

endmodule

/* src/kbd_config.svh */
`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

// one scan code byte, both sides of the translator
`define KBD_CODE_W 8

// start, eight data bits, parity, stop
`define KBD_FRAME_BITS 11

// flops per PS/2 line synchronizer
`define KBD_SYNC_STAGES 2

// set 2 release prefix
`define KBD_BREAK_PREFIX 8'hF0

// reply to the PC after a pb6 reset pulse
`define KBD_SELF_TEST_CODE 8'hAA

// pa bit marking a released key
`define KBD_BREAK_FLAG_BIT 7

`endif

/* src/kbd_pkg.sv */
`include "kbd_config.svh"

package kbd_pkg;

	// byte as sent by the keyboard
	typedef logic [`KBD_CODE_W-1:0] set2_code_t;

	// byte as read by the PC on pa
	typedef logic [`KBD_CODE_W-1:0] xt_code_t;

	// bit position inside one PS/2 frame
	typedef logic [$clog2(`KBD_FRAME_BITS)-1:0] frame_count_t;

	// host-port states
	typedef enum logic [2:0] {
		st_idle,
		st_make_ready,   // key code on pa, irq1 pending
		st_wait_clear,   // waiting for pb7 to drop
		st_break_wait,   // prefix seen, waiting for the key
		st_break_ready,  // released key on pa, irq1 pending
		st_test_hold,    // pb6 held low
		st_test_release  // pb6 back high, waiting for pb7 low
	} host_state_t;

endpackage

/* src/pc_keyboard_if.sv */
module pc_keyboard_if import kbd_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ps2_clk,
	input  logic     ps2_data,
	input  logic     pb6,   // low requests keyboard reset
	input  logic     pb7,   // high while the PC clears the interrupt
	output xt_code_t pa,
	output logic     irq1
);

	set2_code_t rx_code;
	logic       rx_strobe;
	xt_code_t   xt_code;

	ps2_receiver u_rx (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.rx_code   (rx_code),
		.rx_strobe (rx_strobe)
	);

	// combinational, xt_code is ready together with the strobe
	scan_translator u_xlat (
		.rx_code (rx_code),
		.xt_code (xt_code)
	);

	host_port_fsm u_host (
		.clk       (clk),
		.rst_n     (rst_n),
		.xt_code   (xt_code),
		.rx_strobe (rx_strobe),
		.pb6       (pb6),
		.pb7       (pb7),
		.pa        (pa),
		.irq1      (irq1)
	);

endmodule

/* src/ps2_receiver.sv */
`include "kbd_config.svh"

module ps2_receiver import kbd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output set2_code_t rx_code,
	output logic       rx_strobe
);

	localparam int SYNC_MSB = `KBD_SYNC_STAGES - 1;

	logic [SYNC_MSB:0] clk_sync;   // keyboard clock into clk domain
	logic [SYNC_MSB:0] data_sync;
	logic              clk_prev;   // last synchronized ps2_clk level
	logic              clk_fall;
	logic              data_bit;
	logic              data_slot;  // frame position carries a data bit
	logic              last_slot;
	frame_count_t      bit_cnt;

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[SYNC_MSB-1:0], ps2_clk};
			data_sync <= {data_sync[SYNC_MSB-1:0], ps2_data};
			clk_prev  <= clk_sync[SYNC_MSB];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[SYNC_MSB];
	assign data_bit = data_sync[SYNC_MSB];

	// bits 1 to 8 of the frame, start is bit 0
	assign data_slot = (bit_cnt >= frame_count_t'(1)) &&
	                   (bit_cnt <= frame_count_t'(`KBD_CODE_W));
	assign last_slot = (bit_cnt == frame_count_t'(`KBD_FRAME_BITS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= clk_fall & last_slot; // one pulse on the stop bit
			if (clk_fall) begin
				if (last_slot)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + frame_count_t'(1);
			end
		end
	end

	// data arrives lsb first, shift in from the top
	always_ff @(posedge clk) begin
		if (clk_fall && data_slot)
			rx_code <= {data_bit, rx_code[`KBD_CODE_W-1:1]};
	end

	// a frame is eleven keyboard clocks long, so strobes are never adjacent
	a_strobe_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		rx_strobe |=> !rx_strobe
	) else $error("rx_strobe held for two cycles");

endmodule

/* src/scan_translator.sv */
module scan_translator import kbd_pkg::*; (
	input  set2_code_t rx_code,
	output xt_code_t   xt_code
);

	// set 2 in, set 1 out
	function automatic xt_code_t set2_to_set1(input set2_code_t code);
		case (code)
		// error, F9, F5, F3, F1, F2, F12, F10, F8, F6, F4, tab, backtick
		8'h00: return 8'hff; 8'h01: return 8'h43; 8'h02: return 8'h41; 8'h03: return 8'h3f;
		8'h04: return 8'h3d; 8'h05: return 8'h3b; 8'h06: return 8'h3c; 8'h07: return 8'h58;
		8'h08: return 8'h64; 8'h09: return 8'h44; 8'h0a: return 8'h42; 8'h0b: return 8'h40;
		8'h0c: return 8'h3e; 8'h0d: return 8'h0f; 8'h0e: return 8'h29; 8'h0f: return 8'h59;

		// left alt, left shift, left ctrl, Q, 1, Z, S, A, W, 2
		8'h10: return 8'h65; 8'h11: return 8'h38; 8'h12: return 8'h2a; 8'h13: return 8'h70;
		8'h14: return 8'h1d; 8'h15: return 8'h10; 8'h16: return 8'h02; 8'h17: return 8'h5a;
		8'h18: return 8'h66; 8'h19: return 8'h71; 8'h1a: return 8'h2c; 8'h1b: return 8'h1f;
		8'h1c: return 8'h1e; 8'h1d: return 8'h11; 8'h1e: return 8'h03; 8'h1f: return 8'h5b;

		// C, X, D, E, 4, 3, space, V, F, T, R, 5
		8'h20: return 8'h67; 8'h21: return 8'h2e; 8'h22: return 8'h2d; 8'h23: return 8'h20;
		8'h24: return 8'h12; 8'h25: return 8'h05; 8'h26: return 8'h04; 8'h27: return 8'h5c;
		8'h28: return 8'h68; 8'h29: return 8'h39; 8'h2a: return 8'h2f; 8'h2b: return 8'h21;
		8'h2c: return 8'h14; 8'h2d: return 8'h13; 8'h2e: return 8'h06; 8'h2f: return 8'h5d;

		// N, B, H, G, Y, 6, M, J, U, 7, 8
		8'h30: return 8'h69; 8'h31: return 8'h31; 8'h32: return 8'h30; 8'h33: return 8'h23;
		8'h34: return 8'h22; 8'h35: return 8'h15; 8'h36: return 8'h07; 8'h37: return 8'h5e;
		8'h38: return 8'h6a; 8'h39: return 8'h72; 8'h3a: return 8'h32; 8'h3b: return 8'h24;
		8'h3c: return 8'h16; 8'h3d: return 8'h08; 8'h3e: return 8'h09; 8'h3f: return 8'h5f;

		// comma, K, I, O, 0, 9, period, slash, L, semicolon, P, minus
		8'h40: return 8'h6b; 8'h41: return 8'h33; 8'h42: return 8'h25; 8'h43: return 8'h17;
		8'h44: return 8'h18; 8'h45: return 8'h0b; 8'h46: return 8'h0a; 8'h47: return 8'h60;
		8'h48: return 8'h6c; 8'h49: return 8'h34; 8'h4a: return 8'h35; 8'h4b: return 8'h26;
		8'h4c: return 8'h27; 8'h4d: return 8'h19; 8'h4e: return 8'h0c; 8'h4f: return 8'h61;

		// quote, open bracket, equals, caps lock, right shift, enter
		// close bracket, backslash
		8'h50: return 8'h6d; 8'h51: return 8'h73; 8'h52: return 8'h28; 8'h53: return 8'h74;
		8'h54: return 8'h1a; 8'h55: return 8'h0d; 8'h56: return 8'h62; 8'h57: return 8'h6e;
		8'h58: return 8'h3a; 8'h59: return 8'h36; 8'h5a: return 8'h1c; 8'h5b: return 8'h1b;
		8'h5c: return 8'h75; 8'h5d: return 8'h2b; 8'h5e: return 8'h63; 8'h5f: return 8'h76;

		// backspace, keypad 1, 4 and 7
		8'h60: return 8'h55; 8'h61: return 8'h56; 8'h62: return 8'h77; 8'h63: return 8'h78;
		8'h64: return 8'h79; 8'h65: return 8'h7a; 8'h66: return 8'h0e; 8'h67: return 8'h7b;
		8'h68: return 8'h7c; 8'h69: return 8'h4f; 8'h6a: return 8'h7d; 8'h6b: return 8'h4b;
		8'h6c: return 8'h47; 8'h6d: return 8'h7e; 8'h6e: return 8'h7f; 8'h6f: return 8'h6f;

		// rest of keypad, esc, num lock, F11, scroll lock
		8'h70: return 8'h52; 8'h71: return 8'h53; 8'h72: return 8'h50; 8'h73: return 8'h4c;
		8'h74: return 8'h4d; 8'h75: return 8'h48; 8'h76: return 8'h01; 8'h77: return 8'h45;
		8'h78: return 8'h57; 8'h79: return 8'h4e; 8'h7a: return 8'h51; 8'h7b: return 8'h4a;
		8'h7c: return 8'h37; 8'h7d: return 8'h49; 8'h7e: return 8'h46; 8'h7f: return 8'h54;

		// set 2 puts F7 and sysrq above 0x7f
		8'h83: return 8'h41;
		8'h84: return 8'h54;

		default: return code; // upper half passes through, 0xf0 included
		endcase
	endfunction

	assign xt_code = set2_to_set1(rx_code);

endmodule

/* verification/tb_pc_keyboard_if.sv */
`include "kbd_config.svh"

module tb_pc_keyboard_if import kbd_pkg::*; ();

	localparam int RST_CYCLES     = 16;
	localparam int PS2_HALF       = 8;      // clk cycles per keyboard clock phase
	localparam int TIMEOUT_CYCLES = 12000;  // ~40 frames of ~200 cycles plus margin
	localparam int RAND_KEYS      = 20;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     ps2_clk;
	logic     ps2_data;
	logic     pb6;
	logic     pb7;
	xt_code_t pa;
	logic     irq1;

	// expected interrupts queued by the stimulus and drained by the checker
	string    name_q [$];
	xt_code_t exp_q [$];
	int       irq_target = 0;
	int       irq_count  = 0;
	int       cycle_count = 0;

	logic     irq1_prev = 1'b0;
	logic     irq1_rise;
	xt_code_t pa_prev = '0;
	string    got_name;
	xt_code_t got_code;

	int unsigned seed_val;
	set2_code_t  subset_codes [11] = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h5a, 8'h29,
	                                   8'h76, 8'h16, 8'h00, 8'h83, 8'h84};

	pc_keyboard_if u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	always #10 clk = ~clk;

	// expected set 1 code for the keys the tests use
	function automatic xt_code_t ref_translate(input set2_code_t code);
		xt_code_t result;
		case (code)
			8'h1c: result = 8'h1e; // A
			8'h32: result = 8'h30; // B
			8'h21: result = 8'h2e; // C
			8'h23: result = 8'h20; // D
			8'h5a: result = 8'h1c; // enter
			8'h29: result = 8'h39; // space
			8'h76: result = 8'h01; // esc
			8'h16: result = 8'h02; // 1
			8'h00: result = 8'hff;
			8'h83: result = 8'h41; // F7
			8'h84: result = 8'h54; // sysrq
			default: begin
				if (code >= 8'h85 && code != set2_code_t'(`KBD_BREAK_PREFIX))
					result = code;
				else
					result = 'x; // not modelled here
			end
		endcase
		return result;
	endfunction

	task automatic check_code(input string name, input xt_code_t expected,
	                          input xt_code_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic check_level(input string name, input bit expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %b, actual %b", name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// start, 8 data bits lsb first, odd parity, stop
	task automatic send_ps2_byte(input set2_code_t code);
		logic [`KBD_FRAME_BITS-1:0] frame;
		int                         i;
		frame = {1'b1, ~^code, code, 1'b0};
		for (i = 0; i < `KBD_FRAME_BITS; i++) begin
			ps2_data = frame[i];
			repeat (PS2_HALF) next_cycle();
			ps2_clk = 1'b0;
			repeat (PS2_HALF) next_cycle();
			ps2_clk = 1'b1;
		end
		repeat (PS2_HALF) next_cycle(); // idle gap between frames
	endtask

	task automatic expect_irq(input string name, input xt_code_t code);
		name_q.push_back(name);
		exp_q.push_back(code);
		irq_target++;
	endtask

	task automatic wait_for_irq();
		while (irq_count < irq_target)
			@(posedge clk);
		next_cycle();
	endtask

	// irq1 and pa drop one cycle after pb7 is seen
	task automatic acknowledge(input string name);
		pb7 = 1'b1;
		@(negedge clk);
		check_level({name, "_pending_irq1"}, 1'b1, irq1); // pb7 not sampled yet
		next_cycle();
		@(negedge clk);
		check_level({name, "_ack_irq1"}, 1'b0, irq1);
		check_code({name, "_ack_pa"}, '0, pa);
		next_cycle();
		pb7 = 1'b0;
		repeat (2) next_cycle();
		@(negedge clk);
		check_level({name, "_idle_irq1"}, 1'b0, irq1);
		check_code({name, "_idle_pa"}, '0, pa);
		next_cycle();
	endtask

	task automatic press_key(input string name, input set2_code_t code);
		expect_irq(name, ref_translate(code));
		send_ps2_byte(code);
		wait_for_irq();
		acknowledge(name);
	endtask

	task automatic release_key(input string name, input set2_code_t code);
		xt_code_t expected;
		expected = ref_translate(code);
		expected[`KBD_BREAK_FLAG_BIT] = 1'b1;
		expect_irq(name, expected);
		send_ps2_byte(set2_code_t'(`KBD_BREAK_PREFIX));
		send_ps2_byte(code);
		wait_for_irq();
		acknowledge(name);
	endtask

	// checker samples on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (rst_n) begin
			irq1_rise = irq1 && !irq1_prev;
			irq1_prev = irq1;
			if (irq1_rise) begin
				if (exp_q.size() == 0) begin
					$display("irq1 was raised while no key code was expected");
					$display("tests failed");
					$fatal(1);
				end else begin
					got_name = name_q.pop_front();
					got_code = exp_q.pop_front();
					irq_count++;
					check_code({got_name, "_early"}, got_code, pa_prev); // pa leads irq1
					check_code(got_name, got_code, pa);
				end
			end
			pa_prev = pa;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("tests failed");
			$fatal(1);
		end
	end

	initial begin
		int         idx;
		int         i;
		set2_code_t code;

		seed_val = $urandom(32'h1a93);
		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		pb6      = 1'b1;
		pb7      = 1'b0;

		repeat (RST_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		repeat (2) next_cycle();

		// reset values
		@(negedge clk);
		check_code("reset_pa", '0, pa);
		check_level("reset_irq1", 1'b0, irq1);
		next_cycle();

		// make codes
		press_key("make_a", 8'h1c);
		press_key("make_enter", 8'h5a);

		// break prefix then key
		release_key("break_a", 8'h1c);
		release_key("break_esc", 8'h76);

		// upper half of the table
		press_key("exc_f7", 8'h83);
		press_key("exc_sysrq", 8'h84);
		code = set2_code_t'(8'h85 + $urandom % 107);
		press_key($sformatf("ident_%h", code), code);

		// self test then a frame that arrives while irq1 is pending
		expect_irq("self_test", xt_code_t'(`KBD_SELF_TEST_CODE));
		pb6 = 1'b0;
		repeat (4) next_cycle();
		pb6 = 1'b1;
		wait_for_irq();
		send_ps2_byte(8'h21); // dropped
		repeat (8) next_cycle();
		@(negedge clk);
		check_code("self_test_held_pa", xt_code_t'(`KBD_SELF_TEST_CODE), pa);
		check_level("self_test_held_irq1", 1'b1, irq1);
		next_cycle();
		acknowledge("self_test");

		for (i = 0; i < RAND_KEYS; i++) begin
			idx  = int'($urandom % 11);
			code = subset_codes[idx];
			press_key($sformatf("rand_%0d_%h", i, code), code);
		end

		repeat (4) next_cycle();
		$display("all tests passed");
		$finish;
	end

endmodule
